// ==== hw/booth_datapath.sv ====
// radix-2 Booth multiplier datapath
// one add/subtract and arithmetic right shift per enabled cycle
`timescale 1ns/10ps
`default_nettype none

module booth_datapath
  import exec_pkg::*;
(
  input  logic            clk,
  input  logic            arst_n,
  input  logic            mul_load,
  input  logic            mul_step,
  input  logic [XLEN-1:0] multiplicand,
  input  logic [XLEN-1:0] multiplier,
  output logic [XLEN-1:0] product
);

  logic [XLEN:0]   mcand;     // sign extended by one bit
  logic [XLEN:0]   acc_hi;    // extra bit keeps the sum exact
  logic [XLEN-1:0] acc_lo;    // multiplier shifts out, product shifts in
  logic            booth_bit;
  logic [XLEN:0]   sum;

  // recode on the current multiplier bit and the one shifted out last
  always_comb
  begin
    case ({acc_lo[0], booth_bit})
      2'b01:   sum = acc_hi + mcand;
      2'b10:   sum = acc_hi - mcand;
      default: sum = acc_hi;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      mcand     <= '0;
      acc_hi    <= '0;
      acc_lo    <= '0;
      booth_bit <= 1'b0;
    end
    else if (mul_load)
    begin
      mcand     <= {multiplicand[XLEN-1], multiplicand};
      acc_hi    <= '0;
      acc_lo    <= multiplier;
      booth_bit <= 1'b0;
    end
    else if (mul_step)
    begin
      acc_hi    <= {sum[XLEN], sum[XLEN:1]};
      acc_lo    <= {sum[0], acc_lo[XLEN-1:1]};
      booth_bit <= acc_lo[0];
    end
  end

  assign product = acc_lo;

endmodule

`default_nettype wire

// ==== hw/exec_control.sv ====
// execute stage control FSM
// accepts issues, runs the multiplier steps and holds the result register
`timescale 1ns/10ps
`default_nettype none

module exec_control
  import exec_pkg::*;
(
  input  logic            clk,
  input  logic            arst_n,
  input  logic            issue_valid,
  input  decoded_t        dec,
  input  logic [XLEN-1:0] alu_out,
  input  logic [XLEN-1:0] product,
  input  logic            last_step,
  output logic            mul_load,
  output logic            mul_step,
  output logic            busy,
  output logic            result_valid,
  output result_t         result
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_STEP,
    S_DONE
  } state_e;

  state_e               state;
  logic [REG_IDX_W-1:0] mul_rd;

  // operands are taken on the accepting edge while issue is still driven
  assign mul_load = (state == S_IDLE) && issue_valid && dec.is_mul;
  assign mul_step = (state == S_STEP);
  assign busy     = (state != S_IDLE);

  always_ff @(posedge clk)
  begin
    if (mul_load)
      mul_rd <= dec.rd;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state        <= S_IDLE;
      result_valid <= 1'b0;
      result       <= '0;
    end
    else
    begin
      result_valid <= 1'b0; // single-cycle strobe
      case (state)
        S_IDLE:
        begin
          if (mul_load)
            state <= S_STEP;
          else if (issue_valid)
          begin
            result       <= '{rd: dec.rd, value: alu_out, illegal: dec.illegal};
            result_valid <= 1'b1;
          end
        end
        S_STEP:
        begin
          if (last_step)
            state <= S_DONE;
        end
        S_DONE:
        begin
          result       <= '{rd: mul_rd, value: product, illegal: 1'b0};
          result_valid <= 1'b1;
          state        <= S_IDLE; // busy drops with result_valid
        end
        default:
          state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/exec_pkg.sv ====
// execute stage widths, multiplier sizing and latencies
// plus the structs passed between the blocks
`default_nettype none

package exec_pkg;

  localparam int XLEN        = 32;
  localparam int REG_IDX_W   = 5;
  localparam int MUL_STEPS   = 32; // one Booth step per multiplier bit
  localparam int STEP_CNT_W  = 5;
  localparam int ALU_LATENCY = 1;  // issue edge to result_valid
  localparam int MUL_LATENCY = 34;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef struct packed {
    rv_isa_pkg::instr_u    instr;
    logic [XLEN-1:0]       rs1_val;
    logic [XLEN-1:0]       rs2_val;
  } issue_t;

  typedef struct packed {
    logic [REG_IDX_W-1:0] rd;
    logic [XLEN-1:0]      value;
    logic                 illegal;
  } result_t;

  typedef struct packed {
    alu_op_e              alu_op;
    logic [XLEN-1:0]      op_a;
    logic [XLEN-1:0]      op_b;
    logic [REG_IDX_W-1:0] rd;
    logic                 is_mul;
    logic                 illegal;
  } decoded_t;

endpackage

`default_nettype wire

// ==== hw/exec_unit.sv ====
// RV32 execute stage top level
// decode, ALU, sequential Booth multiplier and result control
`timescale 1ns/10ps
`default_nettype none

module exec_unit
  import exec_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  logic    issue_valid,
  input  issue_t  issue,
  output logic    busy,
  output logic    result_valid,
  output result_t result
);

  decoded_t        dec;
  logic [XLEN-1:0] alu_out;
  logic [XLEN-1:0] product;
  logic            mul_load;
  logic            mul_step;
  logic            last_step;

  operand_select operand_select_i (
    .issue (issue),
    .dec   (dec)
  );

  int_alu int_alu_i (
    .alu_op  (dec.alu_op),
    .op_a    (dec.op_a),
    .op_b    (dec.op_b),
    .alu_out (alu_out)
  );

  booth_datapath booth_datapath_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .mul_load     (mul_load),
    .mul_step     (mul_step),
    .multiplicand (dec.op_a),
    .multiplier   (dec.op_b),
    .product      (product)
  );

  mul_step_counter mul_step_counter_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .mul_load  (mul_load),
    .mul_step  (mul_step),
    .last_step (last_step)
  );

  exec_control exec_control_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .issue_valid  (issue_valid),
    .dec          (dec),
    .alu_out      (alu_out),
    .product      (product),
    .last_step    (last_step),
    .mul_load     (mul_load),
    .mul_step     (mul_step),
    .busy         (busy),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

`default_nettype wire

// ==== hw/int_alu.sv ====
// single-cycle integer ALU
// arithmetic, logic, shifts, compares and a pass-through of op_b
`timescale 1ns/10ps
`default_nettype none

module int_alu
  import exec_pkg::*;
(
  input  alu_op_e         alu_op,
  input  logic [XLEN-1:0] op_a,
  input  logic [XLEN-1:0] op_b,
  output logic [XLEN-1:0] alu_out
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = op_b[4:0];
  assign lt_signed   = $signed(op_a) < $signed(op_b);
  assign lt_unsigned = op_a < op_b;

  always_comb
  begin
    case (alu_op)
      ALU_ADD:    alu_out = op_a + op_b;
      ALU_SUB:    alu_out = op_a - op_b;
      ALU_SLL:    alu_out = op_a << shamt;
      ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU:   alu_out = {{(XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:    alu_out = op_a ^ op_b;
      ALU_SRL:    alu_out = op_a >> shamt;
      ALU_SRA:    alu_out = $unsigned($signed(op_a) >>> shamt);
      ALU_OR:     alu_out = op_a | op_b;
      ALU_AND:    alu_out = op_a & op_b;
      ALU_PASS_B: alu_out = op_b; // lui
      default:    alu_out = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/mul_step_counter.sv ====
// Booth step counter, flags the final step of a multiply
`timescale 1ns/10ps
`default_nettype none

module mul_step_counter
  import exec_pkg::*;
(
  input  logic clk,
  input  logic arst_n,
  input  logic mul_load,
  input  logic mul_step,
  output logic last_step
);

  logic [STEP_CNT_W-1:0] step_cnt;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      step_cnt <= '0;
    else if (mul_load)
      step_cnt <= '0;
    else if (mul_step)
      step_cnt <= step_cnt + 1'b1; // wraps back to zero after the last step
  end

  assign last_step = mul_step && (step_cnt == STEP_CNT_W'(MUL_STEPS - 1));

endmodule

`default_nettype wire

// ==== hw/operand_select.sv ====
// instruction decode for the execute stage
// picks ALU operation and operands, flags multiply and unknown opcodes
`timescale 1ns/10ps
`default_nettype none

module operand_select
  import exec_pkg::*;
  import rv_isa_pkg::*;
(
  input  issue_t   issue,
  output decoded_t dec
);

  r_fmt_t r_f;
  i_fmt_t i_f;
  u_fmt_t u_f;

  assign r_f = issue.instr.r_view;
  assign i_f = issue.instr.i_view;
  assign u_f = issue.instr.u_view;

  // alt selects sub on the add code and sra on the right shift
  function automatic alu_op_e alu_op_of(input logic [2:0] f3, input logic alt);
    case (f3)
      F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
      F3_SLL:  return ALU_SLL;
      F3_SLT:  return ALU_SLT;
      F3_SLTU: return ALU_SLTU;
      F3_XOR:  return ALU_XOR;
      F3_SRL:  return alt ? ALU_SRA : ALU_SRL;
      F3_OR:   return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb
  begin
    dec = '{alu_op: ALU_ADD, op_a: '0, op_b: '0, rd: '0, is_mul: 1'b0, illegal: 1'b0};
    case (r_f.opcode)
      OPCODE_OP:
      begin
        if (r_f.funct7[F7_MUL_BIT] && (r_f.funct3 != F3_ADD))
        begin
          dec.illegal = 1'b1; // mulh and divide are not implemented
        end
        else
        begin
          dec.op_a   = issue.rs1_val;
          dec.op_b   = issue.rs2_val;
          dec.rd     = r_f.rd;
          dec.is_mul = r_f.funct7[F7_MUL_BIT];
          dec.alu_op = alu_op_of(r_f.funct3, r_f.funct7[F7_SUB_BIT]);
        end
      end
      OPCODE_OP_IMM:
      begin
        dec.op_a   = issue.rs1_val;
        dec.rd     = i_f.rd;
        dec.alu_op = alu_op_of(i_f.funct3, (i_f.funct3 == F3_SRL) && i_f.imm12[10]);
        if ((i_f.funct3 == F3_SLL) || (i_f.funct3 == F3_SRL))
          dec.op_b = {{(XLEN-5){1'b0}}, i_f.imm12[4:0]}; // shamt only
        else
          dec.op_b = {{(XLEN-12){i_f.imm12[11]}}, i_f.imm12};
      end
      OPCODE_LUI:
      begin
        dec.rd     = u_f.rd;
        dec.op_b   = {u_f.imm20, 12'b0};
        dec.alu_op = ALU_PASS_B;
      end
      default:
        dec.illegal = 1'b1; // rd and operands stay zero
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/rv_isa_pkg.sv ====
// RV32 base ISA encodings used by the execute stage
// major opcodes, function codes and the views of one instruction word
`default_nettype none

package rv_isa_pkg;

  localparam logic [6:0] OPCODE_OP     = 7'b0110011; // register-register
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPCODE_LUI    = 7'b0110111;

  localparam logic [2:0] F3_ADD  = 3'b000; // add, sub and mul share this
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SRL  = 3'b101; // srl and sra
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  localparam int F7_SUB_BIT = 5; // sub, or sra on the shift code
  localparam int F7_MUL_BIT = 0; // M extension group

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // opcode field sits in the same place in every view
  typedef union packed {
    r_fmt_t r_view;
    i_fmt_t i_view;
    u_fmt_t u_view;
  } instr_u;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
  --top-module exec_unit_tb -f tb.f --Mdir obj_dir -o exec_unit_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "build failed with status $status"
  exit "$status"
fi

./obj_dir/exec_unit_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi
exit 0

// ==== tb.f ====
hw/rv_isa_pkg.sv
hw/exec_pkg.sv
hw/operand_select.sv
hw/int_alu.sv
hw/booth_datapath.sv
hw/mul_step_counter.sv
hw/exec_control.sv
hw/exec_unit.sv
tests/exec_unit_assert.sv
tests/exec_unit_tb.sv

// ==== tests/exec_input.txt ====
# columns in hex: instr rs1_val rs2_val rd value illegal
# value is the expected write-back, rd and illegal the expected flags
002081b3 00000005 00000007 03 0000000c 0
02208933 00000007 fffffffd 12 ffffffeb 0
40208233 00000003 00000005 04 fffffffe 0
002092b3 00000001 00000024 05 00000010 0
022089b3 80000000 00000003 13 80000000 0
0020a333 ffffffff 00000001 06 00000001 0
0020b3b3 ffffffff 00000001 07 00000000 0
0020c433 f0f0f0f0 ff00ff00 08 0ff00ff0 0
0020d4b3 80000000 00000004 09 08000000 0
02208a33 12345678 00000000 14 00000000 0
4020d533 80000000 00000004 0a f8000000 0
0020e5b3 12340000 00005678 0b 12345678 0
0020f633 ffff0000 0f0f0f0f 0c 0f0f0000 0
fff08693 00000010 deadbeef 0d 0000000f 0
4030d713 80000010 00000000 0e f0000002 0
02309793 00000011 00000000 0f 00000088 0
ffb0a813 fffffff0 00000000 10 00000001 0
abcde8b7 00000000 00000000 11 abcde000 0
02208ab3 fffffff9 fffffffb 15 00000023 0
00000f8f 11111111 22222222 00 00000000 1
02208b33 00010001 00010001 16 00020001 0
02208bb3 ffffffff ffffffff 17 00000001 0
02208c33 80000000 ffffffff 18 80000000 0

// ==== tests/exec_unit_assert.sv ====
// protocol checks on the execute stage strobes
// bound into the top level
`timescale 1ns/10ps
`default_nettype none

module exec_unit_assert (
  input logic clk,
  input logic arst_n,
  input logic issue_valid,
  input logic busy,
  input logic result_valid
);

  // the DUT drops an issue while a multiply runs
  no_issue_while_busy: assert property (@(posedge clk) disable iff (!arst_n)
    !(issue_valid && busy))
    else $error("issue_valid high while busy");

  result_single_cycle: assert property (@(posedge clk) disable iff (!arst_n)
    result_valid |=> !result_valid)
    else $error("result_valid held for more than one cycle");

  not_busy_with_result: assert property (@(posedge clk) disable iff (!arst_n)
    result_valid |-> !busy)
    else $error("busy high together with result_valid");

  quiet_in_reset: assert property (@(posedge clk)
    !arst_n |-> (!result_valid && !busy))
    else $error("strobes active during reset");

endmodule

bind exec_unit exec_unit_assert exec_unit_assert_i (
  .clk          (clk),
  .arst_n       (arst_n),
  .issue_valid  (issue_valid),
  .busy         (busy),
  .result_valid (result_valid)
);

`default_nettype wire

// ==== tests/exec_unit_tb.sv ====
// testbench for the RV32 execute stage
// reads instructions and expected results from a file, checks values and latency
`timescale 1ns/10ps
`default_nettype none

module exec_unit_tb
  import exec_pkg::*;
  import rv_isa_pkg::*;
();

  localparam int          CLK_PERIOD   = 8;
  localparam int          RESET_CYCLES = 5;
  localparam int          DRIVE_DELAY  = 1; // inputs change this long after the edge
  localparam logic [31:0] LFSR_SEED    = 32'h6148_2856;

  typedef struct packed {
    issue_t  iss;
    result_t exp;
  } vector_t;

  logic        clk;
  logic        arst_n;
  logic        issue_valid;
  issue_t      issue;
  logic        busy;
  logic        result_valid;
  result_t     result;
  vector_t     vectors[$];
  logic        loaded;
  logic [31:0] lfsr_state;

  exec_unit exec_unit_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .issue_valid  (issue_valid),
    .issue        (issue),
    .busy         (busy),
    .result_valid (result_valid),
    .result       (result)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_gap(output int gap);
    logic [1:0] bits;
    for (int i = 0; i < 2; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      bits[i]    = lfsr_state[0]; // one step per bit taken
    end
    gap = int'(bits);
  endtask

  // mul is OP with funct7 bit 0 and the add function code
  function automatic logic is_multiply(input instr_u w);
    return (w.r_view.opcode == OPCODE_OP) && w.r_view.funct7[F7_MUL_BIT]
      && (w.r_view.funct3 == F3_ADD);
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_result(input result_t got, input result_t exp);
    if (got !== exp)
      stop_on_error($sformatf(
        "Mismatch at %0t: result (rd value illegal) got %0d %h %b, expected %0d %h %b",
        $time, got.rd, got.value, got.illegal, exp.rd, exp.value, exp.illegal));
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp)
      stop_on_error($sformatf("Mismatch at %0t: latency got %0d cycles, expected %0d",
        $time, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp));
  endtask

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] rd;
    logic [31:0] val;
    logic [31:0] ill;
    vector_t     v;
    fd = $fopen("tests/exec_input.txt", "r");
    if (fd == 0)
      stop_on_error("could not open the stimulus file tests/exec_input.txt");
    while (!$feof(fd))
    begin
      line = "";
      n    = $fgets(line, fd);
      if ((n > 0) && (line[0] != "#")) // hash lines describe the columns
      begin
        n = $sscanf(line, "%h %h %h %h %h %h", w, a, b, rd, val, ill);
        if (n == 6)
        begin
          v.iss.instr       = w;
          v.iss.rs1_val     = a;
          v.iss.rs2_val     = b;
          v.exp.rd          = rd[REG_IDX_W-1:0];
          v.exp.value       = val;
          v.exp.illegal     = ill[0];
          vectors.push_back(v);
        end
        else if (n > 0)
          stop_on_error({"malformed line in the stimulus file: ", line});
      end
    end
    $fclose(fd);
    if (vectors.size() == 0)
      stop_on_error("the stimulus file holds no instructions");
  endtask

  // issue one instruction and wait for its result
  task automatic run_one(input vector_t v);
    int   cycles;
    int   exp_lat;
    logic mul;
    mul     = is_multiply(v.iss.instr);
    exp_lat = mul ? MUL_LATENCY : ALU_LATENCY;
    while (busy)
    begin
      @(posedge clk);
      #(DRIVE_DELAY);
    end
    issue       = v.iss;
    issue_valid = 1'b1;
    @(posedge clk); // accepting edge
    #(DRIVE_DELAY);
    issue_valid = 1'b0;
    issue       = '0;
    cycles      = 1;
    while (!result_valid)
    begin
      if (mul)
        check_flag("busy", busy, 1'b1);
      @(posedge clk);
      #(DRIVE_DELAY);
      cycles++;
    end
    check_latency(cycles, exp_lat);
    check_result(result, v.exp);
    @(posedge clk); // next issue goes out in the cycle after result_valid
    #(DRIVE_DELAY);
  endtask

  initial
  begin
    int gap;
    clk         = 1'b0;
    arst_n      = 1'b1;
    issue_valid = 1'b0;
    issue       = '0;
    loaded      = 1'b0;
    lfsr_state  = LFSR_SEED;
    #(DRIVE_DELAY);
    arst_n = 1'b0; // real falling edge for the async reset
    load_vectors();
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    arst_n = 1'b1;
    @(posedge clk);
    #(DRIVE_DELAY);
    foreach (vectors[i])
    begin
      run_one(vectors[i]);
      take_gap(gap);
      repeat (gap)
      begin
        @(posedge clk);
        #(DRIVE_DELAY);
      end
    end
    $display("sim passed");
    $finish;
  end

  // worst case per instruction is a multiply plus the longest gap
  initial
  begin
    int limit_cycles;
    wait (loaded);
    limit_cycles = vectors.size() * (MUL_LATENCY + 6) + RESET_CYCLES;
    #(limit_cycles * CLK_PERIOD);
    $display("timed out after %0d cycles before the instruction list was done", limit_cycles);
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire
